// ==== src/pkgMpu.sv ====
//////////////////////////////
// Shared sizes and packed types of the MPU commit path
// Every RTL file refers to these by pkgMpu:: scoped names
//////////////////////////////
`default_nettype none

package pkgMpu;

	//////////////////////////////
	// Sizes
	//////////////////////////////

	localparam int numEntry = 8;		// Commit table entries
	localparam int slotWidth = 3;		// log2 of numEntry
	localparam int numLanes = 3;		// Execution lanes on the completion bus
	localparam int issueNoWidth = 8;

	// Pipeline depth per lane, deliberately unequal so lanes finish out of order
	localparam int laneDepth [numLanes] = '{2, 4, 7};

	//////////////////////////////
	// Types
	//////////////////////////////

	typedef logic [slotWidth-1:0] slotT;		// Index into the commit table
	typedef logic [issueNoWidth-1:0] issueNoT;	// Program-order tag
	typedef logic [1:0] laneSelT;				// Lane index, value 3 unused
	typedef logic [numLanes-1:0] laneMaskT;		// One bit per lane

	// Dispatch request
	typedef struct packed {
		issueNoT issueNo;
		laneSelT lane;
	} issueReqT;

	// Operation in flight through a lane
	typedef struct packed {
		slotT slot;			// Where to report done
		issueNoT issueNo;
	} laneOpT;

	// Completion bus payload
	typedef struct packed {
		slotT slot;
	} completionT;

endpackage

`default_nettype wire

// ==== src/ringBufferControl.sv ====
//////////////////////////////
// Pointer pair and occupancy count for a ring of table entries
//////////////////////////////
`default_nettype none

module ringBufferControl (
	input wire logic clock,
	input wire logic reset,
	input wire logic write,		// Caller guarantees not full
	input wire logic read,		// Caller guarantees not empty
	output pkgMpu::slotT writeSlot,
	output pkgMpu::slotT readSlot,
	output logic full,
	output logic empty
);

	localparam int countWidth = pkgMpu::slotWidth + 1;	// Must hold numEntry itself

	pkgMpu::slotT writePtr;
	pkgMpu::slotT readPtr;
	logic [countWidth-1:0] count;

	// Wrap at numEntry, not just at the power of two
	function automatic pkgMpu::slotT nextSlot(input pkgMpu::slotT ptr);
		if (ptr == pkgMpu::slotT'(pkgMpu::numEntry - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	always_ff @(posedge clock) begin
		if (reset) begin
			writePtr <= '0;
			readPtr <= '0;
			count <= '0;
		end else begin
			if (write) begin
				writePtr <= nextSlot(writePtr);
			end
			if (read) begin
				readPtr <= nextSlot(readPtr);
			end
			case ({write, read})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;	// Both or neither, level stays
			endcase
		end
	end

	assign writeSlot = writePtr;
	assign readSlot = readPtr;

	// Flags from the count only
	assign full = (count == countWidth'(pkgMpu::numEntry));
	assign empty = (count == '0);

endmodule

`default_nettype wire

// ==== src/commitTable.sv ====
//////////////////////////////
// Commit table: slot allocation at issue, done marking at completion
// Retires the oldest entry once done, one per cycle, in issue order
//////////////////////////////
`default_nettype none

module commitTable (
	input wire logic clock,
	input wire logic reset,
	input wire logic allocate,					// Accepted issue, never while full
	output pkgMpu::slotT allocSlot,
	input wire pkgMpu::completionT completion,
	input wire logic completionValid,
	output logic full,
	output logic commitValid,
	output pkgMpu::issueNoT commitNo,
	input wire pkgMpu::issueNoT issueNo			// Tag stored at allocation
);

	//////////////////////////////
	// Entry state
	//////////////////////////////

	logic [pkgMpu::numEntry-1:0] entryValid;
	logic [pkgMpu::numEntry-1:0] entryDone;
	pkgMpu::issueNoT entryIssueNo [pkgMpu::numEntry];

	pkgMpu::slotT writeSlot;
	pkgMpu::slotT headSlot;
	logic empty;
	logic pop;

	ringBufferControl i_ringBufferControl (
		.clock(clock),
		.reset(reset),
		.write(allocate),
		.read(pop),
		.writeSlot(writeSlot),
		.readSlot(headSlot),
		.full(full),
		.empty(empty)
	);

	assign allocSlot = writeSlot;

	// Head ready to retire
	assign pop = ~empty & entryValid[headSlot] & entryDone[headSlot];

	// Valid and done bits
	always_ff @(posedge clock) begin
		if (reset) begin
			entryValid <= '0;
			entryDone <= '0;
		end else begin
			if (pop) begin
				entryValid[headSlot] <= 1'b0;	// Entry frees at the pop edge
			end
			if (completionValid) begin
				entryDone[completion.slot] <= 1'b1;
			end
			// Slot written here is never the head being popped
			if (allocate) begin
				entryValid[writeSlot] <= 1'b1;
				entryDone[writeSlot] <= 1'b0;
			end
		end
	end

	// Tag storage
	always_ff @(posedge clock) begin
		if (allocate) begin
			entryIssueNo[writeSlot] <= issueNo;
		end
	end

	//////////////////////////////
	// Commit output
	//////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			commitValid <= 1'b0;
		end else begin
			commitValid <= pop;		// One cycle after the head is ready
		end
	end

	always_ff @(posedge clock) begin
		if (pop) begin
			commitNo <= entryIssueNo[headSlot];
		end
	end

endmodule

`default_nettype wire

// ==== src/executionLane.sv ====
//////////////////////////////
// Fixed-depth lane pipeline, last stage waits for the completion bus
//////////////////////////////
`default_nettype none

module executionLane #(
	parameter int depth = 2		// Stages between load and request
) (
	input wire logic clock,
	input wire logic reset,
	input wire logic load,		// Never asserted while busy
	input wire pkgMpu::laneOpT op,
	output logic request,
	input wire logic grant,
	output pkgMpu::laneOpT result,
	output logic busy
);

	logic [depth-1:0] stageValid;
	pkgMpu::laneOpT stageOp [depth];
	logic stall;

	// Last stage holds the bus request
	assign request = stageValid[depth-1];
	assign result = stageOp[depth-1];

	// Ungranted request freezes the whole lane
	assign stall = request & ~grant;
	assign busy = stall;

	//////////////////////////////
	// Valid chain
	//////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			stageValid <= '0;
		end else if (!stall) begin
			stageValid[0] <= load;
			for (int s = 1; s < depth; s++) begin
				stageValid[s] <= stageValid[s-1];
			end
		end
	end

	// Payload moves with the valid bits
	always_ff @(posedge clock) begin
		if (!stall) begin
			if (load) begin
				stageOp[0] <= op;
			end
			for (int s = 1; s < depth; s++) begin
				stageOp[s] <= stageOp[s-1];
			end
		end
	end

endmodule

`default_nettype wire

// ==== src/completionArbiter.sv ====
//////////////////////////////
// Round-robin grant of the shared completion bus
//////////////////////////////
`default_nettype none

module completionArbiter (
	input wire logic clock,
	input wire logic reset,
	input wire pkgMpu::laneMaskT request,
	output pkgMpu::laneMaskT grant		// One-hot or zero
);

	pkgMpu::laneSelT lastWinner;
	pkgMpu::laneSelT winner;

	// Search starts at the lane after the last winner
	always_comb begin
		int idx;
		grant = '0;
		winner = lastWinner;
		for (int k = 1; k <= pkgMpu::numLanes; k++) begin
			idx = (int'(lastWinner) + k) % pkgMpu::numLanes;
			if (grant == '0 && request[idx]) begin
				grant[idx] = 1'b1;
				winner = pkgMpu::laneSelT'(idx);
			end
		end
	end

	// Pointer moves on a grant only
	always_ff @(posedge clock) begin
		if (reset) begin
			lastWinner <= pkgMpu::laneSelT'(pkgMpu::numLanes - 1);	// Lane 0 first
		end else if (|grant) begin
			lastWinner <= winner;
		end
	end

endmodule

`default_nettype wire

// ==== src/mpuCommitUnit.sv ====
//////////////////////////////
// MPU retirement path top: issue accept, lanes, completion arbiter
// and commit table; dispatch drives issue, commits come out in order
//////////////////////////////
`default_nettype none

module mpuCommitUnit (
	input wire logic clock,
	input wire logic reset,
	input wire logic issueValid,
	input wire pkgMpu::issueReqT issue,
	output logic full,
	output pkgMpu::laneMaskT laneBusy,
	output logic commitValid,
	output pkgMpu::issueNoT commitNo
);

	//////////////////////////////
	// Issue accept
	//////////////////////////////

	logic laneExists;
	logic accepted;
	pkgMpu::slotT allocSlot;
	pkgMpu::laneMaskT laneLoad;
	pkgMpu::laneOpT newOp;

	assign laneExists = (int'(issue.lane) < pkgMpu::numLanes);	// Lane 3 is dropped
	assign accepted = issueValid & ~full & laneExists & ~laneBusy[issue.lane];

	// One-hot load to the target lane
	always_comb begin
		laneLoad = '0;
		for (int i = 0; i < pkgMpu::numLanes; i++) begin
			laneLoad[i] = accepted && (int'(issue.lane) == i);
		end
	end

	assign newOp = '{slot: allocSlot, issueNo: issue.issueNo};

	//////////////////////////////
	// Lanes
	//////////////////////////////

	pkgMpu::laneMaskT laneRequest;
	pkgMpu::laneMaskT laneGrant;
	pkgMpu::laneOpT laneResult [pkgMpu::numLanes];

	for (genvar i = 0; i < pkgMpu::numLanes; i++) begin : genLane
		executionLane #(
			.depth(pkgMpu::laneDepth[i])
		) i_executionLane (
			.clock(clock),
			.reset(reset),
			.load(laneLoad[i]),
			.op(newOp),
			.request(laneRequest[i]),
			.grant(laneGrant[i]),
			.result(laneResult[i]),
			.busy(laneBusy[i])
		);
	end

	completionArbiter i_completionArbiter (
		.clock(clock),
		.reset(reset),
		.request(laneRequest),
		.grant(laneGrant)
	);

	// Granted lane's slot onto the bus
	pkgMpu::completionT completion;
	logic completionValid;

	always_comb begin
		completion = '0;
		for (int i = 0; i < pkgMpu::numLanes; i++) begin
			if (laneGrant[i]) begin
				completion.slot = laneResult[i].slot;
			end
		end
	end

	assign completionValid = |laneGrant;

	//////////////////////////////
	// Commit table
	//////////////////////////////

	commitTable i_commitTable (
		.clock(clock),
		.reset(reset),
		.allocate(accepted),
		.allocSlot(allocSlot),
		.completion(completion),
		.completionValid(completionValid),
		.full(full),
		.commitValid(commitValid),
		.commitNo(commitNo),
		.issueNo(issue.issueNo)
	);

endmodule

`default_nettype wire

// ==== test/mpuCommit_properties.sv ====
//////////////////////////////
// Concurrent checks on the completion bus and commit strobe,
// bound into the MPU commit top level
//////////////////////////////
`default_nettype none

module mpuCommitProperties (
	input wire logic clock,
	input wire logic reset,
	input wire pkgMpu::laneMaskT request,
	input wire pkgMpu::laneMaskT grant,
	input wire logic commitValid,
	input wire logic tableEmpty		// Ring count is zero
);

	// Single owner of the completion bus
	grantOneHot: assert property (@(posedge clock) disable iff (reset) $onehot0(grant))
		else $error("Completion grant is not one-hot or zero");

	// Grant only to a lane that asks
	grantToRequester: assert property (@(posedge clock) disable iff (reset)
		(grant & ~request) == '0)
		else $error("Grant given to a lane without a request");

	// Registered commit output starts low
	noCommitAfterReset: assert property (@(posedge clock) $fell(reset) |-> !commitValid)
		else $error("Commit in the first cycle after reset");

	// Strobe lags the pop by a cycle
	noCommitFromEmpty: assert property (@(posedge clock) disable iff (reset)
		commitValid |-> !$past(tableEmpty))
		else $error("Commit while the commit table was empty");

endmodule

bind mpuCommitUnit mpuCommitProperties i_mpuCommitProperties (
	.clock(clock),
	.reset(reset),
	.request(laneRequest),
	.grant(laneGrant),
	.commitValid(commitValid),
	.tableEmpty(i_commitTable.empty)
);

`default_nettype wire

// ==== test/tbMpuCommit.sv ====
//////////////////////////////
// Testbench for the MPU commit path: LFSR issue stimulus
// against a queue model of in-order retirement
//////////////////////////////
`default_nettype none

module tbMpuCommit;

	localparam int clockPeriod = 100;
	localparam int resetCycles = 8;
	localparam int numAttempts = 400;
	localparam int drainCycles = 64;
	// Reset, attempts and drain plus some slack
	localparam int timeoutCycles = resetCycles + numAttempts + drainCycles + 128;
	localparam logic [31:0] lfsrSeed = 32'hc4169ef4;

	logic clock;
	logic reset;
	logic issueValid;
	pkgMpu::issueReqT issue;
	logic full;
	pkgMpu::laneMaskT laneBusy;
	logic commitValid;
	pkgMpu::issueNoT commitNo;

	logic [31:0] lfsrState;
	pkgMpu::issueNoT nextIssueNo;		// Tag for the next accepted issue
	pkgMpu::issueNoT expectedQ [$];		// Accepted, not yet committed
	int acceptedCount;
	int cycleCount;

	mpuCommitUnit i_mpuCommitUnit (
		.clock(clock),
		.reset(reset),
		.issueValid(issueValid),
		.issue(issue),
		.full(full),
		.laneBusy(laneBusy),
		.commitValid(commitValid),
		.commitNo(commitNo)
	);

	//////////////////////////////
	// Clock and timeout
	//////////////////////////////

	initial begin
		clock = 1'b0;
		forever #(clockPeriod / 2) clock = ~clock;
	end

	initial begin
		cycleCount = 0;
		while (cycleCount < timeoutCycles) begin
			@(posedge clock);
			cycleCount++;
		end
		$display("Run still going after %0d cycles", timeoutCycles);
		$display("*** TEST FAILED ***");
		$fatal(1, "Timeout: the test did not reach its end in time");
	end

	//////////////////////////////
	// Random bits
	//////////////////////////////

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsrStep(input logic [31:0] state);
		logic feedback;
		feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
		return {state[30:0], feedback};
	endfunction

	// One step per bit taken
	function automatic logic drawBit();
		lfsrState = lfsrStep(lfsrState);
		return lfsrState[0];
	endfunction

	//////////////////////////////
	// Compare tasks
	//////////////////////////////

	task automatic checkIssueNo(input string name, input pkgMpu::issueNoT actual,
			input pkgMpu::issueNoT expected);
		if (actual !== expected) begin
			$display("ERROR at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
			$display("*** TEST FAILED ***");
			$fatal(1, "Wrong value on %s", name);
		end
	endtask

	task automatic checkFlag(input string name, input logic actual, input logic expected);
		if (actual !== expected) begin
			$display("ERROR at %0t: %s expected %b, got %b", $time, name, expected, actual);
			$display("*** TEST FAILED ***");
			$fatal(1, "Wrong value on %s", name);
		end
	endtask

	//////////////////////////////
	// Model
	//////////////////////////////

	// Commits first, so the queue size matches the table count
	task automatic observeCycle();
		pkgMpu::issueNoT expectedNo;
		if (commitValid === 1'b1) begin
			if (expectedQ.size() == 0) begin
				$display("Commit of %0h seen with no accepted issue outstanding", commitNo);
				$display("*** TEST FAILED ***");
				$fatal(1, "Unexpected commit");
			end else begin
				expectedNo = expectedQ.pop_front();		// Oldest accepted
				checkIssueNo("commitNo", commitNo, expectedNo);
			end
		end
		checkFlag("full", full, expectedQ.size() == pkgMpu::numEntry);
	endtask

	// One issue attempt from three LFSR bits
	task automatic driveAttempt();
		logic wantIssue;
		pkgMpu::laneSelT lane;
		logic accept;
		wantIssue = drawBit();
		lane[1] = drawBit();
		lane[0] = drawBit();
		if (lane == 2'd3) begin
			lane = 2'd0;	// Folded onto lane 0
		end
		// Busy lane or full table drops the issue
		accept = wantIssue && !full && !laneBusy[lane];
		issueValid = wantIssue;
		issue.issueNo = nextIssueNo;
		issue.lane = lane;
		if (accept) begin
			expectedQ.push_back(nextIssueNo);
			nextIssueNo++;
			acceptedCount++;
		end
	endtask

	//////////////////////////////
	// Main sequence
	//////////////////////////////

	initial begin
		reset = 1'b1;
		issueValid = 1'b0;
		issue = '0;
		lfsrState = lfsrSeed;
		nextIssueNo = '0;
		acceptedCount = 0;

		repeat (resetCycles) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;

		// State straight out of reset
		checkFlag("commitValid", commitValid, 1'b0);
		checkFlag("full", full, 1'b0);
		for (int i = 0; i < pkgMpu::numLanes; i++) begin
			checkFlag($sformatf("laneBusy[%0d]", i), laneBusy[i], 1'b0);
		end

		for (int n = 0; n < numAttempts; n++) begin
			@(negedge clock);
			observeCycle();
			driveAttempt();
		end

		// No new issues, lanes and table empty out
		for (int n = 0; n < drainCycles; n++) begin
			@(negedge clock);
			observeCycle();
			issueValid = 1'b0;
		end

		if (expectedQ.size() != 0) begin
			$display("%0d accepted issues never committed", expectedQ.size());
			$display("*** TEST FAILED ***");
			$fatal(1, "Drain window ended with issues outstanding");
		end else begin
			$display("%0d issues committed in order", acceptedCount);
			$display("*** TEST PASSED ***");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== sim.f ====
src/pkgMpu.sv
src/ringBufferControl.sv
src/commitTable.sv
src/executionLane.sv
src/completionArbiter.sv
src/mpuCommitUnit.sv
test/mpuCommit_properties.sv
test/tbMpuCommit.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the MPU commit testbench with Verilator.
# Exit status is the simulator's: nonzero on any $fatal.

set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 \
	--top-module tbMpuCommit \
	--Mdir obj_dir \
	-o tbMpuCommit \
	-f sim.f
status=$?
if [ "$status" -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit "$status"
fi

./obj_dir/tbMpuCommit
status=$?
if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit "$status"
fi

exit 0
